// ==== fir_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// Datapath widths, tap counts and fixed-point shift
// constants for the complex FIR
////////////////////////////////////////////////////////////

package fir_cfg_pkg;

  // Rail widths
  localparam int SAMPLE_W    = 24;
  localparam int COEF_W      = 27;
  localparam int PREADD_W    = 25;
  localparam int PROD_W      = 52;
  localparam int ACC_W       = 38;
  localparam int OUT_W       = 32;

  // Filter geometry
  localparam int NUM_TAPS    = 29;
  localparam int NUM_COEFS   = 15;
  localparam int NUM_MACS    = 5;
  localparam int NUM_PHASES  = 3;

  // Fixed-point alignment
  localparam int PROD_SHIFT  = 18;
  localparam int OUT_SHIFT   = 5;

  // Storage sizes
  localparam int FIFO_DEPTH  = 4;
  localparam int COEF_ADDR_W = 4;

endpackage

// ==== fir_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Phase state encoding and controller timing constants
////////////////////////////////////////////////////////////

package fir_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_PH0  = 2'd1,
    ST_PH1  = 2'd2,
    ST_PH2  = 2'd3
  } phase_e;

  // Tap select to phase sum at the accumulator
  localparam int PIPE_DELAY = 4;

endpackage

// ==== sample_fifo.sv ====
////////////////////////////////////////////////////////////
// Four-entry I/Q sample FIFO with full and empty flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_fifo
  import fir_cfg_pkg::*;
(
  input  logic                       clk,
  input  logic                       RST,
  input  logic                       push_i,
  input  logic signed [SAMPLE_W-1:0] samp_i_i,
  input  logic signed [SAMPLE_W-1:0] samp_q_i,
  input  logic                       pop_i,
  output logic signed [SAMPLE_W-1:0] head_i_o,
  output logic signed [SAMPLE_W-1:0] head_q_o,
  output logic                       empty_o,
  output logic                       full_o
);

  // Pointers carry one extra wrap bit
  logic [$clog2(FIFO_DEPTH):0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH):0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] wr_addr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_addr;
  logic                          wr_en;
  logic                          rd_en;

  logic signed [SAMPLE_W-1:0] mem_i [FIFO_DEPTH];
  logic signed [SAMPLE_W-1:0] mem_q [FIFO_DEPTH];

  assign wr_addr = wr_ptr[$clog2(FIFO_DEPTH)-1:0];
  assign rd_addr = rd_ptr[$clog2(FIFO_DEPTH)-1:0];

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[$clog2(FIFO_DEPTH)] != rd_ptr[$clog2(FIFO_DEPTH)]) &&
                   (wr_addr == rd_addr);

  // Pushes while full are dropped
  assign wr_en = push_i && !full_o;
  assign rd_en = pop_i && !empty_o;

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem_i[wr_addr] <= samp_i_i;
      mem_q[wr_addr] <= samp_q_i;
    end
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign head_i_o = mem_i[rd_addr];
  assign head_q_o = mem_q[rd_addr];

  // Controller only pops a non-empty FIFO
  a_no_pop_empty: assert property (@(posedge clk) disable iff (RST)
    pop_i |-> !empty_o);

endmodule

// ==== tap_delay_line.sv ====
////////////////////////////////////////////////////////////
// 29-deep I/Q sample history
// Selects the five mirrored tap pairs of each phase
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tap_delay_line
  import fir_cfg_pkg::*, fir_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       RST,
  input  logic                       shift_i,
  input  logic signed [SAMPLE_W-1:0] new_i_i,
  input  logic signed [SAMPLE_W-1:0] new_q_i,
  input  phase_e                     phase_i,
  output logic signed [SAMPLE_W-1:0] tap_a_i_o [NUM_MACS],
  output logic signed [SAMPLE_W-1:0] tap_a_q_o [NUM_MACS],
  output logic signed [SAMPLE_W-1:0] tap_b_i_o [NUM_MACS],
  output logic signed [SAMPLE_W-1:0] tap_b_q_o [NUM_MACS]
);

  // Index 0 holds the newest sample
  logic signed [SAMPLE_W-1:0] hist_i [NUM_TAPS];
  logic signed [SAMPLE_W-1:0] hist_q [NUM_TAPS];
  logic [1:0]                 grp;

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < NUM_TAPS; k++)
      begin
        hist_i[k] <= '0;
        hist_q[k] <= '0;
      end
    end
    else if (shift_i)
    begin
      hist_i[0] <= new_i_i;
      hist_q[0] <= new_q_i;
      for (int k = 1; k < NUM_TAPS; k++)
      begin
        hist_i[k] <= hist_i[k-1];
        hist_q[k] <= hist_q[k-1];
      end
    end
  end

  assign grp = phase_i - 2'd1;

  always_comb
  begin
    for (int m = 0; m < NUM_MACS; m++)
    begin
      tap_a_i_o[m] = '0;
      tap_a_q_o[m] = '0;
      tap_b_i_o[m] = '0;
      tap_b_q_o[m] = '0;
      if (phase_i != ST_IDLE)
      begin
        tap_a_i_o[m] = hist_i[grp*NUM_MACS + m];
        tap_a_q_o[m] = hist_q[grp*NUM_MACS + m];
        // Centre tap enters on the A side only
        if (NUM_TAPS - 1 - grp*NUM_MACS - m != grp*NUM_MACS + m)
        begin
          tap_b_i_o[m] = hist_i[NUM_TAPS - 1 - grp*NUM_MACS - m];
          tap_b_q_o[m] = hist_q[NUM_TAPS - 1 - grp*NUM_MACS - m];
        end
      end
    end
  end

endmodule

// ==== coef_bank.sv ====
////////////////////////////////////////////////////////////
// Fifteen-entry complex coefficient store
// Presents the five coefficients of the current phase
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module coef_bank
  import fir_cfg_pkg::*, fir_ctrl_pkg::*;
(
  input  logic                          clk,
  input  logic                          RST,
  input  logic                          wr_i,
  input  logic        [COEF_ADDR_W-1:0] addr_i,
  input  logic signed [COEF_W-1:0]      coef_i_i,
  input  logic signed [COEF_W-1:0]      coef_q_i,
  input  phase_e                        phase_i,
  output logic signed [COEF_W-1:0]      coef_sel_i_o [NUM_MACS],
  output logic signed [COEF_W-1:0]      coef_sel_q_o [NUM_MACS]
);

  logic signed [COEF_W-1:0] mem_i [NUM_COEFS];
  logic signed [COEF_W-1:0] mem_q [NUM_COEFS];
  logic [1:0]               grp;

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < NUM_COEFS; k++)
      begin
        mem_i[k] <= '0;
        mem_q[k] <= '0;
      end
    end
    else if (wr_i)
    begin
      mem_i[addr_i] <= coef_i_i;
      mem_q[addr_i] <= coef_q_i;
    end
  end

  assign grp = phase_i - 2'd1;

  always_comb
  begin
    for (int m = 0; m < NUM_MACS; m++)
    begin
      coef_sel_i_o[m] = '0;
      coef_sel_q_o[m] = '0;
      if (phase_i != ST_IDLE)
      begin
        coef_sel_i_o[m] = mem_i[grp*NUM_MACS + m];
        coef_sel_q_o[m] = mem_q[grp*NUM_MACS + m];
      end
    end
  end

  a_coef_addr_range: assert property (@(posedge clk) disable iff (RST)
    wr_i |-> (addr_i < NUM_COEFS));

endmodule

// ==== filter_ctrl.sv ====
////////////////////////////////////////////////////////////
// Phase FSM with FIFO pop, accumulator load and
// output strobe timing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module filter_ctrl
  import fir_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   RST,
  input  logic   fifo_empty_i,
  output logic   pop_o,
  output phase_e phase_o,
  output logic   acc_load_o,
  output logic   push_out_o
);

  phase_e                state_q;
  phase_e                state_d;
  logic [PIPE_DELAY-1:0] first_pipe;
  logic [PIPE_DELAY:0]   last_pipe;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (!fifo_empty_i) state_d = ST_PH0;
      ST_PH0:  state_d = ST_PH1;
      ST_PH1:  state_d = ST_PH2;
      ST_PH2:  state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // Sample enters the delay line on the pop edge
  assign pop_o   = (state_q == ST_IDLE) && !fifo_empty_i;
  assign phase_o = state_q;

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      state_q    <= ST_IDLE;
      first_pipe <= '0;
      last_pipe  <= '0;
    end
    else
    begin
      state_q    <= state_d;
      first_pipe <= {first_pipe[PIPE_DELAY-2:0], state_q == ST_PH0};
      last_pipe  <= {last_pipe[PIPE_DELAY-1:0], state_q == ST_PH2};
    end
  end

  // Load lines up with the first phase sum, push with the final value
  assign acc_load_o = first_pipe[PIPE_DELAY-1];
  assign push_out_o = last_pipe[PIPE_DELAY];

  a_push_single: assert property (@(posedge clk) disable iff (RST)
    push_out_o |=> !push_out_o);

endmodule

// ==== cmac_array.sv ====
////////////////////////////////////////////////////////////
// Five pre-adders, five pipelined complex multipliers
// and the registered phase sum
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cmac_array
  import fir_cfg_pkg::*;
(
  input  logic                       clk,
  input  logic                       RST,
  input  logic signed [SAMPLE_W-1:0] tap_a_i_i [NUM_MACS],
  input  logic signed [SAMPLE_W-1:0] tap_a_q_i [NUM_MACS],
  input  logic signed [SAMPLE_W-1:0] tap_b_i_i [NUM_MACS],
  input  logic signed [SAMPLE_W-1:0] tap_b_q_i [NUM_MACS],
  input  logic signed [COEF_W-1:0]   coef_i_i [NUM_MACS],
  input  logic signed [COEF_W-1:0]   coef_q_i [NUM_MACS],
  output logic signed [ACC_W-1:0]    sum_i_o,
  output logic signed [ACC_W-1:0]    sum_q_o
);

  logic signed [PREADD_W-1:0] pre_i  [NUM_MACS];
  logic signed [PREADD_W-1:0] pre_q  [NUM_MACS];
  logic signed [COEF_W-1:0]   c_i    [NUM_MACS];
  logic signed [COEF_W-1:0]   c_q    [NUM_MACS];
  logic signed [PROD_W-1:0]   p_ac   [NUM_MACS];
  logic signed [PROD_W-1:0]   p_bd   [NUM_MACS];
  logic signed [PROD_W-1:0]   p_bc   [NUM_MACS];
  logic signed [PROD_W-1:0]   p_ad   [NUM_MACS];
  logic signed [PROD_W-1:0]   prod_re [NUM_MACS];
  logic signed [PROD_W-1:0]   prod_im [NUM_MACS];
  logic signed [ACC_W-1:0]    sum_re;
  logic signed [ACC_W-1:0]    sum_im;

  // Stage 1 pre-add with the coefficients riding along
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int m = 0; m < NUM_MACS; m++)
      begin
        pre_i[m] <= '0;
        pre_q[m] <= '0;
        c_i[m]   <= '0;
        c_q[m]   <= '0;
      end
    end
    else
    begin
      for (int m = 0; m < NUM_MACS; m++)
      begin
        pre_i[m] <= tap_a_i_i[m] + tap_b_i_i[m];
        pre_q[m] <= tap_a_q_i[m] + tap_b_q_i[m];
        c_i[m]   <= coef_i_i[m];
        c_q[m]   <= coef_q_i[m];
      end
    end
  end

  // Stages 2 and 3 form (A+jB)(C+jD) = (AC-BD) + j(BC+AD)
  always_ff @(posedge clk)
  begin
    for (int m = 0; m < NUM_MACS; m++)
    begin
      p_ac[m]    <= pre_i[m] * c_i[m];
      p_bd[m]    <= pre_q[m] * c_q[m];
      p_bc[m]    <= pre_q[m] * c_i[m];
      p_ad[m]    <= pre_i[m] * c_q[m];
      prod_re[m] <= p_ac[m] - p_bd[m];
      prod_im[m] <= p_bc[m] + p_ad[m];
    end
  end

  // Floor-shift each product, then add the five
  always_comb
  begin
    sum_re = '0;
    sum_im = '0;
    for (int m = 0; m < NUM_MACS; m++)
    begin
      sum_re = sum_re + ACC_W'(prod_re[m] >>> PROD_SHIFT);
      sum_im = sum_im + ACC_W'(prod_im[m] >>> PROD_SHIFT);
    end
  end

  // Stage 4
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      sum_i_o <= '0;
      sum_q_o <= '0;
    end
    else
    begin
      sum_i_o <= sum_re;
      sum_q_o <= sum_im;
    end
  end

endmodule

// ==== phase_accumulator.sv ====
////////////////////////////////////////////////////////////
// Three-phase accumulation and output rounding
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phase_accumulator
  import fir_cfg_pkg::*;
(
  input  logic                    clk,
  input  logic                    RST,
  input  logic                    load_i,
  input  logic signed [ACC_W-1:0] sum_i_i,
  input  logic signed [ACC_W-1:0] sum_q_i,
  output logic        [OUT_W-1:0] fi_o,
  output logic        [OUT_W-1:0] fq_o
);

  logic signed [ACC_W-1:0] acc_i;
  logic signed [ACC_W-1:0] acc_q;
  logic signed [ACC_W-1:0] rnd_i;
  logic signed [ACC_W-1:0] rnd_q;

  // First phase sum restarts the accumulation
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      acc_i <= '0;
      acc_q <= '0;
    end
    else if (load_i)
    begin
      acc_i <= sum_i_i;
      acc_q <= sum_q_i;
    end
    else
    begin
      acc_i <= acc_i + sum_i_i;
      acc_q <= acc_q + sum_q_i;
    end
  end

  // Add half an LSB, then floor
  assign rnd_i = acc_i + (ACC_W'(1) << (OUT_SHIFT - 1));
  assign rnd_q = acc_q + (ACC_W'(1) << (OUT_SHIFT - 1));

  assign fi_o = OUT_W'(rnd_i >>> OUT_SHIFT);
  assign fq_o = OUT_W'(rnd_q >>> OUT_SHIFT);

endmodule

// ==== cfir_top.sv ====
////////////////////////////////////////////////////////////
// 29-tap symmetric complex FIR top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cfir_top
  import fir_cfg_pkg::*, fir_ctrl_pkg::*;
(
  input  logic                          clk,
  input  logic                          RST,
  input  logic                          push_in_i,
  input  logic signed [SAMPLE_W-1:0]    samp_i_i,
  input  logic signed [SAMPLE_W-1:0]    samp_q_i,
  output logic                          stop_in_o,
  input  logic                          push_coef_i,
  input  logic        [COEF_ADDR_W-1:0] coef_addr_i,
  input  logic signed [COEF_W-1:0]      coef_i_i,
  input  logic signed [COEF_W-1:0]      coef_q_i,
  output logic                          push_out_o,
  output logic        [OUT_W-1:0]       fi_o,
  output logic        [OUT_W-1:0]       fq_o
);

  logic                       fifo_empty;
  logic                       pop;
  logic                       acc_load;
  phase_e                     phase;
  logic signed [SAMPLE_W-1:0] head_i;
  logic signed [SAMPLE_W-1:0] head_q;
  logic signed [SAMPLE_W-1:0] tap_a_i [NUM_MACS];
  logic signed [SAMPLE_W-1:0] tap_a_q [NUM_MACS];
  logic signed [SAMPLE_W-1:0] tap_b_i [NUM_MACS];
  logic signed [SAMPLE_W-1:0] tap_b_q [NUM_MACS];
  logic signed [COEF_W-1:0]   coef_sel_i [NUM_MACS];
  logic signed [COEF_W-1:0]   coef_sel_q [NUM_MACS];
  logic signed [ACC_W-1:0]    sum_i;
  logic signed [ACC_W-1:0]    sum_q;

  sample_fifo u_fifo (
    .clk(clk), .RST(RST),
    .push_i(push_in_i), .samp_i_i(samp_i_i), .samp_q_i(samp_q_i),
    .pop_i(pop), .head_i_o(head_i), .head_q_o(head_q),
    .empty_o(fifo_empty), .full_o(stop_in_o)
  );

  filter_ctrl u_ctrl (
    .clk(clk), .RST(RST),
    .fifo_empty_i(fifo_empty), .pop_o(pop), .phase_o(phase),
    .acc_load_o(acc_load), .push_out_o(push_out_o)
  );

  tap_delay_line u_taps (
    .clk(clk), .RST(RST),
    .shift_i(pop), .new_i_i(head_i), .new_q_i(head_q), .phase_i(phase),
    .tap_a_i_o(tap_a_i), .tap_a_q_o(tap_a_q),
    .tap_b_i_o(tap_b_i), .tap_b_q_o(tap_b_q)
  );

  coef_bank u_coefs (
    .clk(clk), .RST(RST),
    .wr_i(push_coef_i), .addr_i(coef_addr_i),
    .coef_i_i(coef_i_i), .coef_q_i(coef_q_i), .phase_i(phase),
    .coef_sel_i_o(coef_sel_i), .coef_sel_q_o(coef_sel_q)
  );

  cmac_array u_cmac (
    .clk(clk), .RST(RST),
    .tap_a_i_i(tap_a_i), .tap_a_q_i(tap_a_q),
    .tap_b_i_i(tap_b_i), .tap_b_q_i(tap_b_q),
    .coef_i_i(coef_sel_i), .coef_q_i(coef_sel_q),
    .sum_i_o(sum_i), .sum_q_o(sum_q)
  );

  phase_accumulator u_acc (
    .clk(clk), .RST(RST),
    .load_i(acc_load), .sum_i_i(sum_i), .sum_q_i(sum_q),
    .fi_o(fi_o), .fq_o(fq_o)
  );

endmodule

// ==== tb_cfir_checker.sv ====
////////////////////////////////////////////////////////////
// Output monitor for the complex FIR
// Compares each output pair with the expected queue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cfir_checker
  import fir_cfg_pkg::*;
(
  input logic             clk,
  input logic             RST,
  input logic             push_out_i,
  input logic             stop_in_i,
  input logic [OUT_W-1:0] fi_i,
  input logic [OUT_W-1:0] fq_i
);

  int exp_fi [$];
  int exp_fq [$];
  int n_pass = 0;
  int n_fail = 0;
  int n_out  = 0;
  bit saw_full = 1'b0;
  bit idle_bad = 1'b0;

  task automatic add_expected(input int fi, input int fq);
    exp_fi.push_back(fi);
    exp_fq.push_back(fq);
  endtask

  function automatic int pending();
    return exp_fi.size();
  endfunction

  task automatic compare_output();
    int efi;
    int efq;
    if (exp_fi.size() == 0)
    begin
      $display("Output %0d appeared with no expected value pending", n_out);
      n_fail++;
    end
    else
    begin
      efi = exp_fi.pop_front();
      efq = exp_fq.pop_front();
      if ($signed(fi_i) !== efi || $signed(fq_i) !== efq)
      begin
        $display("Error at %0t: output %0d got (%0d, %0d), expected (%0d, %0d)",
                 $time, n_out, $signed(fi_i), $signed(fq_i), efi, efq);
        n_fail++;
      end
      else
      begin
        $display("Output %0d: (%0d, %0d) ok", n_out, efi, efq);
        n_pass++;
      end
    end
    n_out++;
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!RST)
    begin
      // Nothing queued or compared yet, so both strobes stay low
      if (n_out == 0 && exp_fi.size() == 0 && (push_out_i || stop_in_i) && !idle_bad)
      begin
        $display("Error at %0t: strobes high before any sample was pushed", $time);
        idle_bad = 1'b1;
      end
      if (stop_in_i)
        saw_full = 1'b1;
      if (push_out_i)
        compare_output();
    end
  end

  task automatic final_report();
    if (idle_bad)
    begin
      $display("Idle after reset: strobes rose before any sample");
      n_fail++;
    end
    else
    begin
      $display("Idle after reset: strobes low ok");
      n_pass++;
    end
    if (saw_full)
    begin
      $display("Back-pressure: FIFO full seen ok");
      n_pass++;
    end
    else
    begin
      $display("Back-pressure: the input FIFO never reported full");
      n_fail++;
    end
    $display("Checks passed %0d, failed %0d, outputs %0d", n_pass, n_fail, n_out);
  endtask

endmodule

// ==== tb_cfir.sv ====
////////////////////////////////////////////////////////////
// Testbench top for the complex FIR
// Clock, reset, file-driven stimulus and DUT instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cfir
  import fir_cfg_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic                          clk;
  logic                          RST;
  logic                          push_in_i;
  logic signed [SAMPLE_W-1:0]    samp_i_i;
  logic signed [SAMPLE_W-1:0]    samp_q_i;
  logic                          stop_in_o;
  logic                          push_coef_i;
  logic        [COEF_ADDR_W-1:0] coef_addr_i;
  logic signed [COEF_W-1:0]      coef_i_i;
  logic signed [COEF_W-1:0]      coef_q_i;
  logic                          push_out_o;
  logic        [OUT_W-1:0]       fi_o;
  logic        [OUT_W-1:0]       fq_o;

  integer seed = 32'ha80b_661b;

  cfir_top UUT (
    .clk(clk), .RST(RST),
    .push_in_i(push_in_i), .samp_i_i(samp_i_i), .samp_q_i(samp_q_i),
    .stop_in_o(stop_in_o),
    .push_coef_i(push_coef_i), .coef_addr_i(coef_addr_i),
    .coef_i_i(coef_i_i), .coef_q_i(coef_q_i),
    .push_out_o(push_out_o), .fi_o(fi_o), .fq_o(fq_o)
  );

  tb_cfir_checker u_check (
    .clk(clk), .RST(RST),
    .push_out_i(push_out_o), .stop_in_i(stop_in_o),
    .fi_i(fi_o), .fq_i(fq_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $finish;
  endtask

  // Hold off while the FIFO reports full
  task automatic send_sample(input int si, input int sq);
    int guard;
    guard = 0;
    while (stop_in_o)
    begin
      @(negedge clk);
      guard++;
      if (guard > WAIT_LIMIT)
        abort_run("Timeout: input FIFO stayed full");
    end
    push_in_i = 1'b1;
    samp_i_i  = SAMPLE_W'(si);
    samp_q_i  = SAMPLE_W'(sq);
    @(negedge clk);
    push_in_i = 1'b0;
    repeat ($unsigned($random(seed)) % 3)
      @(negedge clk);
  endtask

  task automatic write_coef(input int addr, input int ci, input int cq);
    push_coef_i = 1'b1;
    coef_addr_i = COEF_ADDR_W'(addr);
    coef_i_i    = COEF_W'(ci);
    coef_q_i    = COEF_W'(cq);
    @(negedge clk);
    push_coef_i = 1'b0;
  endtask

  task automatic wait_drained();
    int guard;
    guard = 0;
    while (u_check.pending() != 0)
    begin
      @(negedge clk);
      guard++;
      if (guard > WAIT_LIMIT)
        abort_run("Timeout: expected outputs never arrived");
    end
  endtask

  initial
  begin
    int               fd;
    int               a;
    int               b;
    int               c;
    int               rc;
    byte              kind;
    logic [8*128-1:0] rest;
    clk = 1'b0;
    RST = 1'b1;
    push_in_i = 1'b0;
    samp_i_i = '0;
    samp_q_i = '0;
    push_coef_i = 1'b0;
    coef_addr_i = '0;
    coef_i_i = '0;
    coef_q_i = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    RST = 1'b0;
    // Idle stretch with no output expected
    repeat (12) @(negedge clk);
    fd = $fopen("cfir_testdata.txt", "r");
    if (fd == 0)
      abort_run("Could not open cfir_testdata.txt");
    else
    begin
      while ($fscanf(fd, " %c", kind) == 1)
      begin
        if (kind == "#")
          rc = $fgets(rest, fd);
        else if (kind == "C")
        begin
          rc = $fscanf(fd, "%d %d %d", a, b, c);
          if (rc != 3)
            abort_run("Malformed coefficient line in cfir_testdata.txt");
          else
          begin
            wait_drained();
            write_coef(a, b, c);
          end
        end
        else if (kind == "S")
        begin
          rc = $fscanf(fd, "%d %d", a, b);
          if (rc != 2)
            abort_run("Malformed sample line in cfir_testdata.txt");
          else
            send_sample(a, b);
        end
        else if (kind == "E")
        begin
          rc = $fscanf(fd, "%d %d", a, b);
          if (rc != 2)
            abort_run("Malformed expected line in cfir_testdata.txt");
          else
            u_check.add_expected(a, b);
        end
      end
      $fclose(fd);
      wait_drained();
      repeat (16) @(negedge clk);
      u_check.final_report();
      if (u_check.n_fail == 0)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
      $finish;
    end
  end

  // Overall watchdog
  initial
  begin
    #200000;
    abort_run("Timeout: simulation ran too long");
  end

endmodule

// ==== cfir_testdata.txt ====
# C addr coef_i coef_q | S samp_i samp_q | E fi fq, all decimal
# An E line holds the expected output of the S line before it
C 0 786432 0
C 1 0 131072
C 14 -262144 131072
S 1024 0
E 96 0
S 0 0
E 0 16
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E -32 16
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 0
S 0 0
E 0 16
S 0 0
E 96 0
S 1001 -701
E 94 -66
S -5 7
E 10 16
S 100 200
E 9 19
S -300 50
E -31 6
S 7 -9
E 0 -6
S 11 13
E 1 1
S -1 -1
E 0 0
S 20 -40
E 2 -4
C 0 0 -524288
S 9 4
E 1 0
S -300 -600
E -38 19

// ==== compile.f ====
fir_cfg_pkg.sv
fir_ctrl_pkg.sv
sample_fifo.sv
tap_delay_line.sv
coef_bank.sv
filter_ctrl.sv
cmac_array.sv
phase_accumulator.sv
cfir_top.sv
tb_cfir_checker.sv
tb_cfir.sv

// ==== Bender.yml ====
package:
  name: cfir

sources:
  - fir_cfg_pkg.sv
  - fir_ctrl_pkg.sv
  - sample_fifo.sv
  - tap_delay_line.sv
  - coef_bank.sv
  - filter_ctrl.sv
  - cmac_array.sv
  - phase_accumulator.sv
  - cfir_top.sv
  - target: test
    files:
      - tb_cfir_checker.sv
      - tb_cfir.sv
